//--- hw/bju_defines.svh
`ifndef BJU_DEFINES_SVH
`define BJU_DEFINES_SVH

// Datapath and PC width
`define BJU_XLEN      32

// Physical register index width
`define BJU_REG_W     6

// Architectural x1, the link register
`define BJU_LINK_REG  1

// PC increments for 16-bit and 32-bit instructions
`define BJU_STEP16    2
`define BJU_STEP32    4

// EX1/EX2 state encodings
`define BJU_ST_EX1    1'b0
`define BJU_ST_EX2    1'b1

`endif

//--- hw/bju_pkg.sv
`include "bju_defines.svh"

package bju_pkg;

  // Decoded function field
  typedef struct packed {
    logic auipc;
    logic cond;
    logic uncond;
    logic sgn;
    logic inv;
    logic eq_or_jalr;
    logic lt;
  } bju_func_t;

  // ========================================
  // Inputs
  // ========================================
  typedef struct packed {
    logic                   vld;
    logic                   sel;
    bju_func_t              func;
    logic [`BJU_XLEN-1:0]   src0;
    logic [`BJU_XLEN-1:0]   src1;
    logic [`BJU_REG_W-1:0]  src0_reg;
    logic [`BJU_REG_W-1:0]  dst_preg;
    logic                   wb_vld;
    logic                   inst_len;
    logic [1:0]             bht_pred;
    logic                   depd_src0;
    logic                   depd_src1;
    logic                   split;
  } bju_ex1_t;

  typedef struct packed {
    logic                   data_vld;
    logic [`BJU_XLEN-1:0]   data;
  } bju_lsu_fwd_t;

  typedef struct packed {
    logic                   reset_vld;
    logic [`BJU_XLEN-1:0]   rst_addr;
    logic                   chgflw_vld;
    logic [`BJU_XLEN-1:0]   chgflw_pc;
  } bju_pc_ctrl_t;

  typedef struct packed {
    logic                   cmplt_vld;
    logic                   inst_len;
    logic                   split;
    logic                   ex1_stall;
  } bju_retire_t;

  // Branch held over into EX2
  typedef struct packed {
    bju_func_t              func;
    logic [`BJU_XLEN-1:0]   src0;
    logic [`BJU_XLEN-1:0]   src1;
    logic                   inst_len;
    logic [1:0]             bht_pred;
    logic [`BJU_XLEN-1:0]   not_pred_pc;
  } bju_ex2_t;

  // ========================================
  // Reports
  // ========================================
  typedef struct packed {
    logic                   tar_pc_vld;
    logic [`BJU_XLEN-1:0]   tar_pc;
    logic                   cancel;
  } bju_ifu_redir_t;

  typedef struct packed {
    logic                   br_vld;
    logic                   taken;
    logic [1:0]             pred;
    logic                   mispred;
    logic [`BJU_XLEN-1:0]   cur_pc;
  } bju_bht_rpt_t;

  typedef struct packed {
    logic                   ret_vld;
    logic                   link_vld;
    logic                   ind_link_vld;
    logic                   pc_mispred;
  } bju_ras_rpt_t;

  typedef struct packed {
    logic                   rslt_vld;
    logic [`BJU_XLEN-1:0]   rslt;
    logic                   stall;
    logic                   no_op;
  } bju_dp_rpt_t;

  typedef struct packed {
    logic                   inst_vld;
    logic                   cmplt;
    logic                   inst_len;
    logic [`BJU_XLEN-1:0]   next_pc;
    logic [`BJU_XLEN-1:0]   cur_pc;
    logic                   ex2_next_pc_vld;
    logic [`BJU_XLEN-1:0]   ex2_next_pc;
    logic                   flush;
  } bju_rtu_rpt_t;

endpackage

//--- hw/bju_ex2_hold.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_ex2_hold (
  input  logic                  bju_fwd_clk,
  input  logic                  cpurst_b,
  input  bju_pkg::bju_ex1_t     ex1,
  input  bju_pkg::bju_lsu_fwd_t lsu,
  input  logic [`BJU_XLEN-1:0]  not_pred_pc,
  input  logic                  ras_set,
  output logic                  in_ex2,
  output bju_pkg::bju_ex2_t     ex2,
  output logic                  fwd_vld,
  output logic                  depd_lsu,
  output logic                  stall
);

  logic cond_sel;
  logic cur_state;
  logic next_state;

  // ========================================
  // Load dependency
  // ========================================
  // Only conditional branches wait on a load
  assign cond_sel = ex1.sel && ex1.func.cond;
  assign depd_lsu = cond_sel && (ex1.depd_src0 || ex1.depd_src1);

  // Load data arrives for a waiting branch
  assign fwd_vld  = ex1.vld && depd_lsu && lsu.data_vld && !in_ex2;

  // ========================================
  // EX1/EX2 state machine
  // ========================================
  always_comb
  begin
    case (cur_state)
      `BJU_ST_EX1: next_state = fwd_vld ? `BJU_ST_EX2 : `BJU_ST_EX1;
      default:     next_state = `BJU_ST_EX1;
    endcase
  end

  always_ff @(posedge bju_fwd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= `BJU_ST_EX1;
    else
      cur_state <= next_state;
  end

  assign in_ex2 = (cur_state == `BJU_ST_EX2);

  // ========================================
  // EX2 holding registers
  // ========================================
  always_ff @(posedge bju_fwd_clk)
  begin
    if (fwd_vld)
    begin
      ex2.func     <= ex1.func;
      ex2.inst_len <= ex1.inst_len;
      ex2.bht_pred <= ex1.bht_pred;
      // Take the load data on the dependent source
      ex2.src0     <= ex1.depd_src0 ? lsu.data : ex1.src0;
      ex2.src1     <= ex1.depd_src1 ? lsu.data : ex1.src1;
    end
  end

  // Also keeps the JALR target for the delayed redirect
  always_ff @(posedge bju_fwd_clk)
  begin
    if (fwd_vld || ras_set)
      ex2.not_pred_pc <= not_pred_pc;
  end

  // Waiting for load data, or resolving in EX2
  assign stall = (ex1.vld && depd_lsu && !fwd_vld) || in_ex2;

endmodule

//--- hw/bju_cond_cmp.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_cond_cmp (
  input  logic                  in_ex2,
  input  bju_pkg::bju_func_t    ex1_func,
  input  logic [`BJU_XLEN-1:0]  ex1_src0,
  input  logic [`BJU_XLEN-1:0]  ex1_src1,
  input  bju_pkg::bju_ex2_t     ex2,
  output logic                  cond_taken
);

  import bju_pkg::*;

  bju_func_t            func;
  logic [`BJU_XLEN-1:0] src0;
  logic [`BJU_XLEN-1:0] src1;
  logic                 eq;
  logic                 ult;
  logic                 slt;
  logic                 lt_res;

  // Held operands win during EX2
  assign func = in_ex2 ? ex2.func : ex1_func;
  assign src0 = in_ex2 ? ex2.src0 : ex1_src0;
  assign src1 = in_ex2 ? ex2.src1 : ex1_src1;

  assign eq  = (src0 == src1);
  assign ult = (src0 < src1);

  // Signed compare from sign bits and the unsigned result
  assign slt = (src0[`BJU_XLEN-1] && src1[`BJU_XLEN-1] && ult)
            || (src0[`BJU_XLEN-1] && !src1[`BJU_XLEN-1])
            || (!src0[`BJU_XLEN-1] && !src1[`BJU_XLEN-1] && ult);

  assign lt_res = func.sgn ? slt : ult;

  // BEQ/BNE on eq, BLT/BGE and unsigned forms on lt
  assign cond_taken = ((eq ^ func.inv) && func.eq_or_jalr)
                   || ((lt_res ^ func.inv) && func.lt);

endmodule

//--- hw/bju_pcgen.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_pcgen (
  input  logic                  bju_fwd_clk,
  input  logic                  cpurst_b,
  input  bju_pkg::bju_pc_ctrl_t pc_ctrl,
  input  bju_pkg::bju_retire_t  retire,
  input  logic [`BJU_XLEN-1:0]  next_pc,
  output logic [`BJU_XLEN-1:0]  cur_pc,
  output logic [`BJU_XLEN-1:0]  inc_pc
);

  // Halfword aligned, bit 0 is always zero
  logic [`BJU_XLEN-1:1] pc_q;
  logic                 retire_load;
  logic [`BJU_XLEN-1:0] step;

  // ========================================
  // PC register
  // ========================================
  // Split instructions advance only on their last part
  assign retire_load = retire.cmplt_vld && !retire.ex1_stall && !retire.split;

  always_ff @(posedge bju_fwd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pc_q <= '0;
    else if (pc_ctrl.reset_vld)
      pc_q <= pc_ctrl.rst_addr[`BJU_XLEN-1:1];
    else if (pc_ctrl.chgflw_vld)
      pc_q <= pc_ctrl.chgflw_pc[`BJU_XLEN-1:1];
    else if (retire_load)
      pc_q <= next_pc[`BJU_XLEN-1:1];
  end

  assign cur_pc = {pc_q, 1'b0};

  // ========================================
  // Incrementer
  // ========================================
  assign step   = retire.inst_len ? `BJU_STEP32 : `BJU_STEP16;
  assign inc_pc = cur_pc + step;

endmodule

//--- hw/bju_redirect.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_redirect (
  input  logic                    bju_fwd_clk,
  input  logic                    cpurst_b,
  input  bju_pkg::bju_ex1_t       ex1,
  input  logic                    depd_lsu,
  input  logic                    in_ex2,
  input  bju_pkg::bju_ex2_t       ex2,
  input  logic                    cond_taken,
  input  logic [`BJU_XLEN-1:0]    ag_tar_pc,
  input  logic [`BJU_XLEN-1:0]    ifu_pc_pred,
  input  logic [`BJU_XLEN-1:0]    cur_pc,
  input  logic [`BJU_XLEN-1:0]    inc_pc,
  output logic [`BJU_XLEN-1:0]    next_pc,
  output logic [`BJU_XLEN-1:0]    not_pred_pc,
  output logic                    ras_set,
  output bju_pkg::bju_ifu_redir_t ifu,
  output bju_pkg::bju_bht_rpt_t   bht,
  output bju_pkg::bju_ras_rpt_t   ras,
  output bju_pkg::bju_dp_rpt_t    dp,
  output bju_pkg::bju_rtu_rpt_t   rtu
);

  import bju_pkg::*;

  localparam logic [`BJU_REG_W-1:0] LINK_REG = `BJU_LINK_REG;

  bju_func_t  func;
  logic       no_depd_cmplt;
  logic [1:0] bht_pred;
  logic       br_taken;
  logic       ex1_mispred;
  logic       ex2_mispred;
  logic       jalr;
  logic       src_is_link;
  logic       src_dst_equal;
  logic       link_raw;
  logic       pc_mispred;
  logic       ras_mispred_q;
  logic       held_redir;

  // ========================================
  // Operand prepare and next PC
  // ========================================
  assign func          = ex1.sel ? ex1.func : '0;
  assign no_depd_cmplt = ex1.vld && ex1.sel && !depd_lsu;
  assign bht_pred      = in_ex2 ? ex2.bht_pred : ex1.bht_pred;

  // A waiting branch follows its prediction
  assign br_taken = (no_depd_cmplt || in_ex2) ? cond_taken : ex1.bht_pred[1];

  assign next_pc     = ((func.cond && br_taken) || func.uncond) ? ag_tar_pc : inc_pc;
  assign not_pred_pc = (func.cond && bht_pred[1]) ? inc_pc : ag_tar_pc;

  // BHT mispredicts
  assign ex1_mispred = func.cond && (cond_taken ^ bht_pred[1]) && no_depd_cmplt;
  assign ex2_mispred = in_ex2 && (cond_taken ^ ex2.bht_pred[1]);

  // ========================================
  // JALR and return stack
  // ========================================
  assign jalr          = func.uncond && func.eq_or_jalr;
  assign src_is_link   = (ex1.src0_reg == LINK_REG);
  assign src_dst_equal = (ex1.src0_reg == ex1.dst_preg) && ex1.wb_vld;
  assign link_raw      = (ex1.dst_preg == LINK_REG) && func.uncond && ex1.wb_vld;

  // Return through x1 with a wrong target, redirected next cycle
  assign ras_set = ex1.vld && jalr && src_is_link
                && (src_dst_equal || (ag_tar_pc != ifu_pc_pred));

  // Indirect jump not through x1 has no RAS prediction
  assign pc_mispred = ex1.vld && jalr && !src_is_link;

  always_ff @(posedge bju_fwd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ras_mispred_q <= 1'b0;
    else
      ras_mispred_q <= ras_set;
  end

  assign held_redir = ex2_mispred || ras_mispred_q;

  // ========================================
  // Reports
  // ========================================
  assign ifu.tar_pc_vld = ex1_mispred || pc_mispred || held_redir;
  assign ifu.tar_pc     = held_redir ? ex2.not_pred_pc : next_pc;
  assign ifu.cancel     = ifu.tar_pc_vld;

  assign bht.br_vld  = (func.cond && no_depd_cmplt) || in_ex2;
  assign bht.taken   = (func.cond || in_ex2) && br_taken;
  assign bht.pred    = bht_pred;
  assign bht.mispred = ex1_mispred || ex2_mispred;
  assign bht.cur_pc  = cur_pc;

  assign ras.ret_vld      = ex1.vld && jalr && src_is_link && !src_dst_equal;
  assign ras.link_vld     = ex1.vld && link_raw;
  assign ras.ind_link_vld = ex1.vld && link_raw && jalr;
  assign ras.pc_mispred   = pc_mispred;

  // Link result or AUIPC sum, stall is added at the top level
  assign dp.rslt_vld = (func.uncond || func.auipc) && ex1.wb_vld && ex1.vld;
  assign dp.rslt     = func.auipc ? ag_tar_pc : inc_pc;
  assign dp.stall    = 1'b0;
  assign dp.no_op    = !in_ex2 && !ras_mispred_q;

  assign rtu.inst_vld        = (ex1.vld && ex1.sel) || in_ex2;
  assign rtu.cmplt           = ((func.cond || func.uncond || func.auipc) && no_depd_cmplt)
                            || in_ex2;
  assign rtu.inst_len        = in_ex2 ? ex2.inst_len : ex1.inst_len;
  assign rtu.next_pc         = next_pc;
  assign rtu.cur_pc          = cur_pc;
  assign rtu.ex2_next_pc_vld = ex2_mispred;
  assign rtu.ex2_next_pc     = ex2.not_pred_pc;
  assign rtu.flush           = held_redir;

endmodule

//--- hw/bju_top.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_top (
  input  logic                    bju_fwd_clk,
  input  logic                    cpurst_b,
  input  bju_pkg::bju_ex1_t       ex1,
  input  logic [`BJU_XLEN-1:0]    ag_tar_pc,
  input  logic [`BJU_XLEN-1:0]    ifu_pc_pred,
  input  bju_pkg::bju_lsu_fwd_t   lsu,
  input  bju_pkg::bju_pc_ctrl_t   pc_ctrl,
  input  bju_pkg::bju_retire_t    retire,
  output bju_pkg::bju_ifu_redir_t ifu,
  output bju_pkg::bju_bht_rpt_t   bht,
  output bju_pkg::bju_ras_rpt_t   ras,
  output bju_pkg::bju_dp_rpt_t    dp,
  output bju_pkg::bju_rtu_rpt_t   rtu,
  output logic                    idu_stall
);

  import bju_pkg::*;

  logic                 in_ex2;
  bju_ex2_t             ex2;
  logic                 depd_lsu;
  logic                 stall;
  logic                 cond_taken;
  logic [`BJU_XLEN-1:0] cur_pc;
  logic [`BJU_XLEN-1:0] inc_pc;
  logic [`BJU_XLEN-1:0] next_pc;
  logic [`BJU_XLEN-1:0] not_pred_pc;
  logic                 ras_set;
  bju_dp_rpt_t          dp_raw;

  // ========================================
  // Load-dependent hold
  // ========================================
  bju_ex2_hold u_ex2_hold (
    .bju_fwd_clk (bju_fwd_clk),
    .cpurst_b    (cpurst_b),
    .ex1         (ex1),
    .lsu         (lsu),
    .not_pred_pc (not_pred_pc),
    .ras_set     (ras_set),
    .in_ex2      (in_ex2),
    .ex2         (ex2),
    .fwd_vld     (),
    .depd_lsu    (depd_lsu),
    .stall       (stall)
  );

  bju_cond_cmp u_cond_cmp (
    .in_ex2     (in_ex2),
    .ex1_func   (ex1.func),
    .ex1_src0   (ex1.src0),
    .ex1_src1   (ex1.src1),
    .ex2        (ex2),
    .cond_taken (cond_taken)
  );

  bju_pcgen u_pcgen (
    .bju_fwd_clk (bju_fwd_clk),
    .cpurst_b    (cpurst_b),
    .pc_ctrl     (pc_ctrl),
    .retire      (retire),
    .next_pc     (next_pc),
    .cur_pc      (cur_pc),
    .inc_pc      (inc_pc)
  );

  // ========================================
  // Redirect and reports
  // ========================================
  bju_redirect u_redirect (
    .bju_fwd_clk (bju_fwd_clk),
    .cpurst_b    (cpurst_b),
    .ex1         (ex1),
    .depd_lsu    (depd_lsu),
    .in_ex2      (in_ex2),
    .ex2         (ex2),
    .cond_taken  (cond_taken),
    .ag_tar_pc   (ag_tar_pc),
    .ifu_pc_pred (ifu_pc_pred),
    .cur_pc      (cur_pc),
    .inc_pc      (inc_pc),
    .next_pc     (next_pc),
    .not_pred_pc (not_pred_pc),
    .ras_set     (ras_set),
    .ifu         (ifu),
    .bht         (bht),
    .ras         (ras),
    .dp          (dp_raw),
    .rtu         (rtu)
  );

  // Merge the hold stall into the datapath report
  assign dp = '{rslt_vld: dp_raw.rslt_vld, rslt: dp_raw.rslt,
                stall: stall, no_op: dp_raw.no_op};

  assign idu_stall = in_ex2;

endmodule

//--- testbench/bju_tb.sv
`timescale 1ns/1ps
`include "bju_defines.svh"

module bju_tb;

  import bju_pkg::*;

  localparam logic [`BJU_REG_W-1:0] LINK_REG = `BJU_LINK_REG;
  localparam logic [31:0]           ALIGN    = 32'hffff_fffe;

  logic                 bju_fwd_clk;
  logic                 cpurst_b;
  bju_ex1_t             ex1;
  logic [`BJU_XLEN-1:0] ag_tar_pc;
  logic [`BJU_XLEN-1:0] ifu_pc_pred;
  bju_lsu_fwd_t         lsu;
  bju_pc_ctrl_t         pc_ctrl;
  bju_retire_t          retire;
  bju_ifu_redir_t       ifu;
  bju_bht_rpt_t         bht;
  bju_ras_rpt_t         ras;
  bju_dp_rpt_t          dp;
  bju_rtu_rpt_t         rtu;
  logic                 idu_stall;

  integer      seed;
  // Reference model state
  logic [31:0] model_pc;
  logic [31:0] pc_pending;
  logic [31:0] held_npp;
  logic        model_ras_flag;

  bju_top bju_top_i (.*);

  initial
  begin
    bju_fwd_clk = 1'b0;
    forever #4 bju_fwd_clk = ~bju_fwd_clk;
  end

  // ========================================
  // Checking and stimulus helpers
  // ========================================
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  // Falling edge, PC register takes what the last rising edge loaded
  task automatic tick();
    @(negedge bju_fwd_clk);
    model_pc = pc_pending;
  endtask

  task automatic clear_inputs();
    ex1         = '0;
    ag_tar_pc   = '0;
    ifu_pc_pred = '0;
    lsu         = '0;
    pc_ctrl     = '0;
    retire      = '0;
  endtask

  function automatic logic [31:0] step_size(input logic len);
    step_size = len ? `BJU_STEP32 : `BJU_STEP16;
  endfunction

  // Kinds 0 to 5 are BEQ, BNE, BLT, BGE, BLTU, BGEU
  function automatic bju_func_t branch_func(input int kind);
    bju_func_t f;
    f            = '0;
    f.cond       = 1'b1;
    f.eq_or_jalr = (kind < 2);
    f.lt         = (kind >= 2);
    f.inv        = (kind == 1) || (kind == 3) || (kind == 5);
    f.sgn        = (kind == 2) || (kind == 3);
    return f;
  endfunction

  function automatic logic branch_outcome(input int kind, input logic [31:0] a,
                                          input logic [31:0] b);
    case (kind)
      0:       return a == b;
      1:       return a != b;
      2:       return $signed(a) < $signed(b);
      3:       return $signed(a) >= $signed(b);
      4:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic pick_operands(output logic [31:0] a, output logic [31:0] b);
    logic [31:0] r;
    r = $random(seed);
    a = $random(seed);
    // Equal operands a quarter of the time
    b = (r[1:0] == 2'd0) ? a : $random(seed);
  endtask

  task automatic load_branch(input int kind, input logic [31:0] a, input logic [31:0] b);
    ex1          = '0;
    ex1.vld      = 1'b1;
    ex1.sel      = 1'b1;
    ex1.func     = branch_func(kind);
    ex1.src0     = a;
    ex1.src1     = b;
    ex1.inst_len = 1'b1;
    ex1.bht_pred = 2'($random(seed));
  endtask

  // ========================================
  // PC generator
  // ========================================
  task automatic run_pc_sequence(input int count);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_next;
    logic        taken;
    int          kind;
    for (int i = 0; i < count; i++)
    begin
      tick();
      clear_inputs();
      r                  = $random(seed);
      pc_ctrl.reset_vld  = (r[2:0] == 3'd0);
      pc_ctrl.rst_addr   = $random(seed);
      pc_ctrl.chgflw_vld = (r[4:3] == 2'd0);
      pc_ctrl.chgflw_pc  = $random(seed);
      retire.cmplt_vld   = r[5];
      retire.ex1_stall   = (r[7:6] == 2'd0);
      retire.split       = (r[9:8] == 2'd0);
      retire.inst_len    = r[10];
      ag_tar_pc          = $random(seed) & ALIGN;
      taken              = 1'b0;
      if (r[11])
      begin
        kind = int'(r[14:12]) % 6;
        pick_operands(a, b);
        load_branch(kind, a, b);
        taken = branch_outcome(kind, a, b);
      end
      #1;
      exp_next = taken ? ag_tar_pc : model_pc + step_size(r[10]);
      check_value("pcgen cur_pc", model_pc, rtu.cur_pc);
      check_value("pcgen next_pc", exp_next, rtu.next_pc);
      // Reset beats change of flow beats retire
      if (pc_ctrl.reset_vld)
        pc_pending = pc_ctrl.rst_addr & ALIGN;
      else if (pc_ctrl.chgflw_vld)
        pc_pending = pc_ctrl.chgflw_pc & ALIGN;
      else if (retire.cmplt_vld && !retire.ex1_stall && !retire.split)
        pc_pending = exp_next & ALIGN;
    end
  endtask

  // ========================================
  // Conditional branches
  // ========================================
  task automatic run_independent_branches(input int count);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_next;
    logic        taken;
    logic        mispred;
    for (int i = 0; i < count; i++)
    begin
      tick();
      clear_inputs();
      r = $random(seed);
      pick_operands(a, b);
      load_branch(int'(r % 6), a, b);
      ex1.inst_len    = r[9];
      ag_tar_pc       = $random(seed) & ALIGN;
      retire.inst_len = r[8];
      #1;
      taken    = branch_outcome(int'(r % 6), a, b);
      mispred  = taken ^ ex1.bht_pred[1];
      exp_next = taken ? ag_tar_pc : model_pc + step_size(r[8]);
      check_value("branch br_vld", 32'(1'b1), 32'(bht.br_vld));
      check_value("branch taken", 32'(taken), 32'(bht.taken));
      check_value("branch mispred", 32'(mispred), 32'(bht.mispred));
      check_value("branch pred", 32'(ex1.bht_pred), 32'(bht.pred));
      check_value("branch bht cur_pc", model_pc, bht.cur_pc);
      check_value("branch redirect", 32'(mispred), 32'(ifu.tar_pc_vld));
      check_value("branch cancel", 32'(mispred), 32'(ifu.cancel));
      check_value("branch next_pc", exp_next, rtu.next_pc);
      check_value("branch inst_vld", 32'(1'b1), 32'(rtu.inst_vld));
      check_value("branch cmplt", 32'(1'b1), 32'(rtu.cmplt));
      check_value("branch inst_len", 32'(r[9]), 32'(rtu.inst_len));
      check_value("branch ex2_next_pc_vld", 32'(1'b0), 32'(rtu.ex2_next_pc_vld));
      check_value("branch no_op", 32'(1'b1), 32'(dp.no_op));
      if (mispred)
        check_value("branch target", exp_next, ifu.tar_pc);
    end
  endtask

  task automatic expect_waiting();
    #1;
    check_value("load wait stall", 32'(1'b1), 32'(dp.stall));
    check_value("load wait idu_stall", 32'(1'b0), 32'(idu_stall));
    check_value("load wait br_vld", 32'(1'b0), 32'(bht.br_vld));
    check_value("load wait cmplt", 32'(1'b0), 32'(rtu.cmplt));
  endtask

  task automatic run_load_branches(input int count);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ld;
    logic [31:0] held_a;
    logic [31:0] held_b;
    logic        taken;
    logic        mispred;
    int          wait_count;
    for (int i = 0; i < count; i++)
    begin
      tick();
      clear_inputs();
      r  = $random(seed);
      ld = $random(seed);
      pick_operands(a, b);
      load_branch(int'(r % 6), a, b);
      ex1.depd_src0   = r[4];
      ex1.depd_src1   = !r[4] || r[5];
      ex1.inst_len    = r[9];
      ag_tar_pc       = $random(seed) & ALIGN;
      retire.inst_len = r[8];
      // Held EX2 operands and the not-predicted PC
      held_a   = ex1.depd_src0 ? ld : a;
      held_b   = ex1.depd_src1 ? ld : b;
      held_npp = ex1.bht_pred[1] ? model_pc + step_size(r[8]) : ag_tar_pc;
      taken    = branch_outcome(int'(r % 6), held_a, held_b);
      mispred  = taken ^ ex1.bht_pred[1];
      expect_waiting();
      repeat (int'(r[14:12]))
      begin
        tick();
        expect_waiting();
      end
      tick();
      lsu.data_vld = 1'b1;
      lsu.data     = ld;
      #1;
      check_value("load fwd stall", 32'(1'b0), 32'(dp.stall));
      tick();
      lsu = '0;
      #1;
      wait_count = 0;
      while (!idu_stall)
      begin
        wait_count++;
        if (wait_count > 4)
          report_failure("timeout waiting for the EX2 cycle of a load-dependent branch");
        tick();
        #1;
      end
      check_value("ex2 latency", 32'd0, wait_count);
      check_value("ex2 stall", 32'(1'b1), 32'(dp.stall));
      check_value("ex2 br_vld", 32'(1'b1), 32'(bht.br_vld));
      check_value("ex2 taken", 32'(taken), 32'(bht.taken));
      check_value("ex2 mispred", 32'(mispred), 32'(bht.mispred));
      check_value("ex2 pred", 32'(ex1.bht_pred), 32'(bht.pred));
      check_value("ex2 redirect", 32'(mispred), 32'(ifu.tar_pc_vld));
      check_value("ex2 cancel", 32'(mispred), 32'(ifu.cancel));
      check_value("ex2 flush", 32'(mispred), 32'(rtu.flush));
      check_value("ex2 cmplt", 32'(1'b1), 32'(rtu.cmplt));
      check_value("ex2 inst_len", 32'(r[9]), 32'(rtu.inst_len));
      check_value("ex2 no_op", 32'(1'b0), 32'(dp.no_op));
      check_value("ex2 next_pc_vld", 32'(mispred), 32'(rtu.ex2_next_pc_vld));
      check_value("ex2 next_pc", held_npp, rtu.ex2_next_pc);
      if (mispred)
        check_value("ex2 target", held_npp, ifu.tar_pc);
      tick();
      clear_inputs();
      #1;
      check_value("ex2 one cycle", 32'(1'b0), 32'(idu_stall));
      check_value("ex2 redirect over", 32'(1'b0), 32'(ifu.tar_pc_vld));
    end
  endtask

  // ========================================
  // JAL, AUIPC and JALR
  // ========================================
  task automatic run_link_results(input int count);
    logic [31:0] r;
    logic [31:0] exp_inc;
    logic        link;
    for (int i = 0; i < count; i++)
    begin
      tick();
      clear_inputs();
      r                = $random(seed);
      ex1.vld          = 1'b1;
      ex1.sel          = 1'b1;
      ex1.func.auipc   = r[0];
      ex1.func.uncond  = !r[0];
      ex1.wb_vld       = r[1];
      ex1.dst_preg     = r[2] ? LINK_REG : r[8:3];
      ex1.src0_reg     = 6'd2;
      ag_tar_pc        = $random(seed) & ALIGN;
      retire.inst_len  = r[9];
      #1;
      exp_inc = model_pc + step_size(r[9]);
      link    = !r[0] && r[1] && (ex1.dst_preg == LINK_REG);
      check_value("link rslt_vld", 32'(r[1]), 32'(dp.rslt_vld));
      check_value("link rslt", r[0] ? ag_tar_pc : exp_inc, dp.rslt);
      check_value("link link_vld", 32'(link), 32'(ras.link_vld));
      check_value("link next_pc", r[0] ? exp_inc : ag_tar_pc, rtu.next_pc);
      check_value("link redirect", 32'(1'b0), 32'(ifu.tar_pc_vld));
      check_value("link cmplt", 32'(1'b1), 32'(rtu.cmplt));
    end
  endtask

  task automatic run_jalr(input int count);
    logic [31:0] r;
    logic        via_link;
    logic        same;
    logic        link;
    for (int i = 0; i < count; i++)
    begin
      tick();
      clear_inputs();
      r                   = $random(seed);
      ex1.vld             = 1'b1;
      ex1.sel             = 1'b1;
      ex1.func.uncond     = 1'b1;
      ex1.func.eq_or_jalr = 1'b1;
      ex1.src0_reg        = (r[1:0] == 2'd0) ? r[7:2] : LINK_REG;
      ex1.dst_preg        = r[8] ? LINK_REG : r[14:9];
      ex1.wb_vld          = r[15];
      ag_tar_pc           = $random(seed) & ALIGN;
      ifu_pc_pred         = r[16] ? ag_tar_pc : ($random(seed) & ALIGN);
      retire.inst_len     = r[17];
      #1;
      via_link       = (ex1.src0_reg == LINK_REG);
      same           = (ex1.src0_reg == ex1.dst_preg) && ex1.wb_vld;
      link           = (ex1.dst_preg == LINK_REG) && ex1.wb_vld;
      model_ras_flag = via_link && (same || (ag_tar_pc != ifu_pc_pred));
      held_npp       = ag_tar_pc;
      check_value("jalr ret_vld", 32'(via_link && !same), 32'(ras.ret_vld));
      check_value("jalr link_vld", 32'(link), 32'(ras.link_vld));
      check_value("jalr ind_link_vld", 32'(link), 32'(ras.ind_link_vld));
      check_value("jalr pc_mispred", 32'(!via_link), 32'(ras.pc_mispred));
      check_value("jalr ex1 redirect", 32'(!via_link), 32'(ifu.tar_pc_vld));
      check_value("jalr next_pc", ag_tar_pc, rtu.next_pc);
      if (!via_link)
        check_value("jalr ex1 target", ag_tar_pc, ifu.tar_pc);
      // Return-stack mismatch redirects one cycle later
      tick();
      clear_inputs();
      #1;
      check_value("jalr late redirect", 32'(model_ras_flag), 32'(ifu.tar_pc_vld));
      check_value("jalr late flush", 32'(model_ras_flag), 32'(rtu.flush));
      check_value("jalr late no_op", 32'(!model_ras_flag), 32'(dp.no_op));
      if (model_ras_flag)
        check_value("jalr late target", held_npp, ifu.tar_pc);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin
    seed           = 32'hadae;
    cpurst_b       = 1'b0;
    model_pc       = '0;
    pc_pending     = '0;
    held_npp       = '0;
    model_ras_flag = 1'b0;
    clear_inputs();
    repeat (4) @(posedge bju_fwd_clk);
    @(negedge bju_fwd_clk);
    cpurst_b = 1'b1;
    #1;
    check_value("reset cur_pc", 32'd0, rtu.cur_pc);
    check_value("reset idu_stall", 32'(1'b0), 32'(idu_stall));
    check_value("reset redirect", 32'(1'b0), 32'(ifu.tar_pc_vld));
    check_value("reset flush", 32'(1'b0), 32'(rtu.flush));
    run_pc_sequence(40);
    run_independent_branches(60);
    run_load_branches(20);
    run_link_results(20);
    run_jalr(30);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+hw
hw/bju_pkg.sv
hw/bju_ex2_hold.sv
hw/bju_cond_cmp.sv
hw/bju_pcgen.sv
hw/bju_redirect.sv
hw/bju_top.sv
testbench/bju_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the BJU testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module bju_tb -o bju_sim \
  && ./obj_dir/bju_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
